// File: verilog/idli_pkg.sv
// Shared widths, register numbers, opcodes and decoded control for the
// nibble-serial execute core.
package idli_pkg;

  // Words move through the datapath one slice at a time, LSB first.
  localparam int unsigned SLICE_W    = 4;
  localparam int unsigned WORD_W     = 16;
  localparam int unsigned NUM_SLICES = WORD_W / SLICE_W;
  localparam int unsigned NUM_PINS   = 4;

  typedef logic [SLICE_W-1:0]            slice_t;
  typedef logic [WORD_W-1:0]             word_t;
  typedef logic [$clog2(NUM_SLICES)-1:0] ctr_t;
  typedef logic [3:0]                    reg_t;
  typedef logic [NUM_PINS-1:0]           pins_t;
  typedef logic [$clog2(NUM_PINS)-1:0]   pin_idx_t;

  // Conditional-execution state, one bit per upcoming instruction.
  typedef logic [7:0] cond_t;

  // The top two registers are not storage. ZR always reads zero and IN
  // returns the external input nibble for the current slice.
  localparam reg_t REG_ZR = 4'd15;
  localparam reg_t REG_IN = 4'd14;

  // Opcodes live in the top nibble of every instruction.
  // Encodings 12 to 14 are unused and decode to NOP.
  typedef enum logic [3:0] {
    OP_ADD     = 4'h0,
    OP_SUB     = 4'h1,
    OP_AND     = 4'h2,
    OP_OR      = 4'h3,
    OP_XOR     = 4'h4,
    OP_CMP_EQ  = 4'h5,
    OP_CMP_LT  = 4'h6,
    OP_CMP_LTU = 4'h7,
    OP_OUT     = 4'h8,
    OP_PIN_IN  = 4'h9,
    OP_PIN_OUT = 4'hA,
    OP_COND    = 4'hB,
    OP_NOP     = 4'hF
  } op_t;

  // Register form used by the ALU, compare, OUT and pin instructions.
  typedef struct packed {
    op_t  op;
    reg_t dst;
    reg_t lhs;
    reg_t rhs;
  } instr_reg_t;

  // Condition form. The pin field shares the dst nibble of the register form.
  typedef struct packed {
    op_t        op;
    logic [3:0] pin;
    cond_t      cond;
  } instr_cond_t;

  typedef union packed {
    instr_reg_t  r;
    instr_cond_t c;
  } instr_t;

  // Flags from the ALU, only meaningful on the last slice.
  typedef struct packed {
    logic z;
    logic n;
    logic c;
    logic v;
  } alu_flags_t;

  // Decoded control held for the whole executing slot.
  typedef struct packed {
    op_t      op;
    reg_t     dst;
    reg_t     lhs;
    reg_t     rhs;
    pin_idx_t pin;
    cond_t    cond;
    logic     vld;
  } ex_ctl_t;

endpackage

// File: verilog/idli_decode.sv
`timescale 1ns/100ps

// Instruction latch and decoder.
module idli_decode import idli_pkg::*; (
  input  var logic    i_ex_gck,
  input  var logic    i_ex_rst_n,

  input  var ctr_t    i_de_ctr,
  input  var instr_t  i_de_instr,
  input  var logic    i_de_instr_vld,

  output var ex_ctl_t o_de_ctl
);

  // Instruction for the slot now executing.
  instr_t instr_q;
  logic   vld_q;

  // The valid bit is control state and comes out of reset clear, so nothing
  // runs in the first slot.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      vld_q <= '0;
    end else if (&i_de_ctr) begin
      vld_q <= i_de_instr_vld;
    end
  end

  // The encoding itself only matters while the valid bit is set.
  always_ff @(posedge i_ex_gck) begin
    if (&i_de_ctr) begin
      instr_q <= i_de_instr;
    end
  end

  // Both views of the union are read here. Operands come from the register
  // view, while the pin index and cond field come from the condition view.
  always_comb begin
    o_de_ctl      = '0;
    o_de_ctl.vld  = vld_q;
    o_de_ctl.op   = instr_q.r.op;
    o_de_ctl.dst  = instr_q.r.dst;
    o_de_ctl.lhs  = instr_q.r.lhs;
    o_de_ctl.rhs  = instr_q.r.rhs;
    o_de_ctl.pin  = instr_q.c.pin[$bits(pin_idx_t)-1:0];
    o_de_ctl.cond = instr_q.c.cond;

    unique case (instr_q.r.op)
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_OUT: ;
      // Compares only write P, so the destination is parked on ZR.
      OP_CMP_EQ, OP_CMP_LT, OP_CMP_LTU: o_de_ctl.dst = REG_ZR;
      // Pin instructions name their register in the lhs field.
      OP_PIN_IN, OP_PIN_OUT: o_de_ctl.dst = instr_q.r.lhs;
      // COND has no register operands at all.
      OP_COND: begin
        o_de_ctl.dst = REG_ZR;
        o_de_ctl.lhs = REG_ZR;
        o_de_ctl.rhs = REG_ZR;
      end
      // Unused encodings become NOP with no writes.
      default: begin
        o_de_ctl.op  = OP_NOP;
        o_de_ctl.dst = REG_ZR;
      end
    endcase
  end

endmodule

// File: verilog/idli_rf.sv
`timescale 1ns/100ps

// Register file with one slice read and written per cycle.
module idli_rf import idli_pkg::*; (
  input  var logic    i_ex_gck,

  input  var ctr_t    i_rf_ctr,
  input  var ex_ctl_t i_rf_ctl,
  input  var logic    i_rf_run,

  input  var slice_t  i_rf_in_data,
  input  var slice_t  i_rf_alu,
  input  var slice_t  i_rf_pin,

  output var slice_t  o_rf_lhs,
  output var slice_t  o_rf_rhs
);

  // Only registers below IN hold state.
  word_t  regs [REG_IN];
  slice_t in_slice;
  logic   wr_en;
  slice_t wr_data;

  // IN carries the input nibble on slice 0 only, so it reads zero-extended.
  always_comb in_slice = ~|i_rf_ctr ? i_rf_in_data : '0;

  // Slice read for each operand. ZR and IN are handled here, not stored.
  always_comb begin
    o_rf_lhs = '0;
    o_rf_rhs = '0;
    if (i_rf_ctl.lhs == REG_IN) o_rf_lhs = in_slice;
    else if (i_rf_ctl.lhs < REG_IN) o_rf_lhs = regs[i_rf_ctl.lhs][i_rf_ctr*SLICE_W +: SLICE_W];
    if (i_rf_ctl.rhs == REG_IN) o_rf_rhs = in_slice;
    else if (i_rf_ctl.rhs < REG_IN) o_rf_rhs = regs[i_rf_ctl.rhs][i_rf_ctr*SLICE_W +: SLICE_W];
  end

  // ALU opcodes write the ALU slice and PIN_IN writes the pin slice.
  // Writes to ZR and IN are dropped.
  always_comb begin
    wr_en   = i_rf_run && i_rf_ctl.dst < REG_IN
           && i_rf_ctl.op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_PIN_IN};
    wr_data = i_rf_ctl.op == OP_PIN_IN ? i_rf_pin : i_rf_alu;
  end

  // One slice lands per cycle, in step with the ALU output.
  always_ff @(posedge i_ex_gck) begin
    if (wr_en) begin
      regs[i_rf_ctl.dst][i_rf_ctr*SLICE_W +: SLICE_W] <= wr_data;
    end
  end

endmodule

// File: verilog/idli_alu.sv
`timescale 1ns/100ps

// Serial ALU working on one slice per cycle.
module idli_alu import idli_pkg::*; (
  input  var logic       i_ex_gck,

  input  var ctr_t       i_alu_ctr,
  input  var ex_ctl_t    i_alu_ctl,
  input  var logic       i_alu_run,

  input  var slice_t     i_alu_lhs,
  input  var slice_t     i_alu_rhs,

  output var slice_t     o_alu_out,
  output var logic       o_alu_out_vld,
  output var alu_flags_t o_alu_flags
);

  // Subtraction and all compares use the inverted rhs path.
  logic            sub;
  slice_t          rhs_x;
  logic            cin;
  logic [SLICE_W:0] sum;
  logic            carry_q;
  logic            z_acc;
  logic            z_q;

  // Carry into slice 0 comes from the opcode, then from the previous slice.
  always_comb begin
    sub   = i_alu_ctl.op inside {OP_SUB, OP_CMP_EQ, OP_CMP_LT, OP_CMP_LTU};
    rhs_x = sub ? ~i_alu_rhs : i_alu_rhs;
    cin   = ~|i_alu_ctr ? sub : carry_q;
    sum   = {1'b0, i_alu_lhs} + {1'b0, rhs_x} + {{SLICE_W{1'b0}}, cin};
  end

  // Zero is built up over the word, restarting on slice 0.
  always_comb z_acc = (~|i_alu_ctr || z_q) && ~|sum[SLICE_W-1:0];

  // Carry and zero move from slice to slice, so no reset is needed.
  always_ff @(posedge i_ex_gck) begin
    carry_q <= sum[SLICE_W];
    z_q     <= z_acc;
  end

  // Result slice. OUT streams the ADD of its two operands.
  always_comb begin
    unique case (i_alu_ctl.op)
      OP_AND:  o_alu_out = i_alu_lhs & i_alu_rhs;
      OP_OR:   o_alu_out = i_alu_lhs | i_alu_rhs;
      OP_XOR:  o_alu_out = i_alu_lhs ^ i_alu_rhs;
      default: o_alu_out = sum[SLICE_W-1:0];
    endcase
  end

  // Flags are read by the predicate logic on the last slice only.
  // Overflow is set when both inputs share a sign that the sum lacks.
  always_comb begin
    o_alu_flags.z = z_acc;
    o_alu_flags.n = sum[SLICE_W-1];
    o_alu_flags.c = sum[SLICE_W];
    o_alu_flags.v = (i_alu_lhs[SLICE_W-1] == rhs_x[SLICE_W-1])
                 && (sum[SLICE_W-1] != i_alu_lhs[SLICE_W-1]);
  end

  // The port strobe covers all four slices of an executed OUT.
  always_comb o_alu_out_vld = i_alu_run && i_alu_ctl.op == OP_OUT;

endmodule

// File: verilog/idli_pred.sv
`timescale 1ns/100ps

// Predicate flag, conditional-execution state and the skip decision.
module idli_pred import idli_pkg::*; (
  input  var logic       i_ex_gck,
  input  var logic       i_ex_rst_n,

  input  var ctr_t       i_pr_ctr,
  input  var ex_ctl_t    i_pr_ctl,
  input  var alu_flags_t i_pr_flags,

  output var logic       o_pr_run,
  output var logic       o_pr_pred
);

  logic  pred_q;
  logic  pred_d;
  cond_t cond_q;
  logic  skip;

  // The state only counts as active while some bit above the LSB is set.
  // An active state runs the instruction only when P matches bit 0.
  always_comb begin
    skip     = |cond_q[7:1] && (pred_q != cond_q[0]);
    o_pr_run = i_pr_ctl.vld && !skip;
  end

  // New value of P from the compare flags of the last slice.
  always_comb begin
    unique case (i_pr_ctl.op)
      OP_CMP_EQ:  pred_d = i_pr_flags.z;
      OP_CMP_LT:  pred_d = i_pr_flags.n != i_pr_flags.v;
      OP_CMP_LTU: pred_d = !i_pr_flags.c;
      default:    pred_d = pred_q;
    endcase
  end

  // P is written at the end of the slot by an executed compare.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      pred_q <= '0;
    end else if (&i_pr_ctr && o_pr_run) begin
      pred_q <= pred_d;
    end
  end

  // An executed COND loads a fresh state. Every other valid instruction,
  // run or skipped, consumes one bit of it.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      cond_q <= '0;
    end else if (&i_pr_ctr && i_pr_ctl.vld) begin
      if (o_pr_run && i_pr_ctl.op == OP_COND) begin
        cond_q <= i_pr_ctl.cond;
      end else begin
        cond_q <= {1'b0, cond_q[7:1]};
      end
    end
  end

  always_comb o_pr_pred = pred_q;

endmodule

// File: verilog/idli_pins.sv
`timescale 1ns/100ps

// IO pins. Inputs are sampled every cycle and outputs are held in a register.
module idli_pins import idli_pkg::*; (
  input  var logic    i_ex_gck,
  input  var logic    i_ex_rst_n,

  input  var ctr_t    i_pn_ctr,
  input  var ex_ctl_t i_pn_ctl,
  input  var logic    i_pn_run,
  input  var logic    i_pn_lhs_bit,

  input  var pins_t   i_pn_io_pins,
  output var slice_t  o_pn_slice,
  output var pins_t   o_pn_io_pins
);

  pins_t in_pins_q;
  pins_t out_pins_q;

  // Plain sample of the external pins.
  always_ff @(posedge i_ex_gck) begin
    in_pins_q <= i_pn_io_pins;
  end

  // PIN_IN writes the pin value zero-extended, so only slice 0 carries it.
  always_comb o_pn_slice = ~|i_pn_ctr ? slice_t'(in_pins_q[i_pn_ctl.pin]) : '0;

  // PIN_OUT takes bit 0 of its register, which is present on slice 0.
  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      out_pins_q <= '0;
    end else if (i_pn_run && ~|i_pn_ctr && i_pn_ctl.op == OP_PIN_OUT) begin
      out_pins_q[i_pn_ctl.pin] <= i_pn_lhs_bit;
    end
  end

  always_comb o_pn_io_pins = out_pins_q;

endmodule

// File: verilog/idli_ex.sv
`timescale 1ns/100ps

// Execute core top. Holds the slice counter and connects the units.
module idli_ex import idli_pkg::*; (
  input  var logic   i_ex_gck,
  input  var logic   i_ex_rst_n,

  // Instruction stream, sampled at the end of each slot.
  input  var instr_t i_ex_instr,
  input  var logic   i_ex_instr_vld,

  // Input nibble read through register IN.
  input  var slice_t i_ex_in_data,

  // Output port, one slice per cycle.
  output var slice_t o_ex_out_data,
  output var logic   o_ex_out_vld,

  // IO pins and predicate flag.
  input  var pins_t  i_ex_io_pins,
  output var pins_t  o_ex_io_pins,
  output var logic   o_ex_pred
);

  // Slice counter shared by every unit. Zero is slice 0 of a slot.
  ctr_t ctr_q;

  ex_ctl_t    ctl;
  logic       run;
  slice_t     lhs;
  slice_t     rhs;
  slice_t     alu_out;
  alu_flags_t flags;
  slice_t     pin_slice;

  always_ff @(posedge i_ex_gck, negedge i_ex_rst_n) begin
    if (!i_ex_rst_n) begin
      ctr_q <= '0;
    end else begin
      ctr_q <= ctr_q + 1'b1;
    end
  end

  idli_decode decode_u (
    .i_ex_gck       (i_ex_gck),
    .i_ex_rst_n     (i_ex_rst_n),
    .i_de_ctr       (ctr_q),
    .i_de_instr     (i_ex_instr),
    .i_de_instr_vld (i_ex_instr_vld),
    .o_de_ctl       (ctl)
  );

  idli_rf rf_u (
    .i_ex_gck     (i_ex_gck),
    .i_rf_ctr     (ctr_q),
    .i_rf_ctl     (ctl),
    .i_rf_run     (run),
    .i_rf_in_data (i_ex_in_data),
    .i_rf_alu     (alu_out),
    .i_rf_pin     (pin_slice),
    .o_rf_lhs     (lhs),
    .o_rf_rhs     (rhs)
  );

  idli_alu alu_u (
    .i_ex_gck      (i_ex_gck),
    .i_alu_ctr     (ctr_q),
    .i_alu_ctl     (ctl),
    .i_alu_run     (run),
    .i_alu_lhs     (lhs),
    .i_alu_rhs     (rhs),
    .o_alu_out     (alu_out),
    .o_alu_out_vld (o_ex_out_vld),
    .o_alu_flags   (flags)
  );

  // The predicate unit decides whether the decoded instruction runs.
  idli_pred pred_u (
    .i_ex_gck   (i_ex_gck),
    .i_ex_rst_n (i_ex_rst_n),
    .i_pr_ctr   (ctr_q),
    .i_pr_ctl   (ctl),
    .i_pr_flags (flags),
    .o_pr_run   (run),
    .o_pr_pred  (o_ex_pred)
  );

  idli_pins pins_u (
    .i_ex_gck     (i_ex_gck),
    .i_ex_rst_n   (i_ex_rst_n),
    .i_pn_ctr     (ctr_q),
    .i_pn_ctl     (ctl),
    .i_pn_run     (run),
    .i_pn_lhs_bit (lhs[0]),
    .i_pn_io_pins (i_ex_io_pins),
    .o_pn_slice   (pin_slice),
    .o_pn_io_pins (o_ex_io_pins)
  );

  // Result slices go straight to the port. The strobe marks valid ones.
  always_comb o_ex_out_data = alu_out;

endmodule

// File: tests/idli_ex_chk.sv
`timescale 1ns/100ps

// Timing properties of the execute core outputs, checked against the slice counter.
module idli_ex_chk import idli_pkg::*; (
  input var logic  i_ex_gck,
  input var logic  i_ex_rst_n,
  input var ctr_t  i_ctr,
  input var logic  i_out_vld,
  input var pins_t i_io_pins,
  input var logic  i_pred
);

  // A stream starts on slice 0 and then covers the rest of the slot.
  assert property (@(posedge i_ex_gck) disable iff (!i_ex_rst_n)
    (i_out_vld && i_ctr == 0) |-> ##1 i_out_vld ##1 i_out_vld ##1 i_out_vld)
    else $error("out strobe shorter than four cycles");

  // The strobe only rises or falls at a slot boundary.
  assert property (@(posedge i_ex_gck) disable iff (!i_ex_rst_n)
    ($rose(i_out_vld) || $fell(i_out_vld)) |-> i_ctr == 0)
    else $error("out strobe edge away from slice 0");

  // Output pins move only on the edge that ends slice 0.
  assert property (@(posedge i_ex_gck) disable iff (!i_ex_rst_n)
    $changed(i_io_pins) |-> $past(i_ctr) == 0)
    else $error("pins changed outside slice 0");

  // P moves only on the edge that ends slice 3.
  assert property (@(posedge i_ex_gck) disable iff (!i_ex_rst_n)
    $changed(i_pred) |-> $past(i_ctr) == 3)
    else $error("P changed outside slice 3");

endmodule

bind idli_ex idli_ex_chk i_idli_ex_chk (
  .i_ex_gck   (i_ex_gck),
  .i_ex_rst_n (i_ex_rst_n),
  .i_ctr      (ctr_q),
  .i_out_vld  (o_ex_out_vld),
  .i_io_pins  (o_ex_io_pins),
  .i_pred     (o_ex_pred)
);

// File: tests/idli_ex_mon.sv
`timescale 1ns/100ps

// Monitor that collects the output stream and compares each slot with the table.
module idli_ex_mon import idli_pkg::*; (
  input  var logic   i_clk,
  input  var slice_t i_out_data,
  input  var logic   i_out_vld,
  input  var logic   i_pred,
  input  var pins_t  i_io_pins,
  input  var logic   i_check,
  input  var int     i_row,
  input  var word_t  i_exp_word,
  input  var logic   i_exp_out,
  input  var logic   i_exp_pred,
  input  var pins_t  i_exp_pins,
  output var int     o_checked,
  output var int     o_errors
);

  word_t word;
  int    vld_cnt;
  int    row_errs;

  initial begin
    word      = '0;
    vld_cnt   = 0;
    o_checked = 0;
    o_errors  = 0;
  end

  // Outputs are sampled mid cycle, where they are settled.
  // A check compares the slot just finished, then starts a new capture.
  always @(negedge i_clk) begin
    if (i_check) begin
      row_errs = 0;
      if ((vld_cnt != 0) != i_exp_out) begin
        $display("** Error at %0t: row %0d out strobe seen %0d cycles, expected stream %0b",
                 $time, i_row, vld_cnt, i_exp_out);
        row_errs++;
      end else if (i_exp_out && (vld_cnt != NUM_SLICES || word !== i_exp_word)) begin
        $display("** Error at %0t: row %0d out word %h over %0d cycles, expected %h",
                 $time, i_row, word, vld_cnt, i_exp_word);
        row_errs++;
      end
      if (i_pred !== i_exp_pred) begin
        $display("** Error at %0t: row %0d P is %b, expected %b",
                 $time, i_row, i_pred, i_exp_pred);
        row_errs++;
      end
      if (i_io_pins !== i_exp_pins) begin
        $display("** Error at %0t: row %0d pins are %b, expected %b",
                 $time, i_row, i_io_pins, i_exp_pins);
        row_errs++;
      end
      $display("row %0d: %s", i_row, row_errs == 0 ? "ok" : "mismatch");
      o_checked++;
      o_errors += row_errs;
      word    = '0;
      vld_cnt = 0;
    end
    // Slices arrive LSB first, so each new one shifts in from the top.
    if (i_out_vld) begin
      word = {i_out_data, word[WORD_W-1:SLICE_W]};
      vld_cnt++;
    end
  end

endmodule

// File: tests/tb_idli_ex.sv
`timescale 1ns/100ps

// Testbench for the execute core. One table row is issued per slot.
module tb_idli_ex import idli_pkg::*;;

  // Row of stimulus and the values expected once it has executed.
  typedef struct packed {
    instr_t instr;
    logic   vld;
    slice_t in_data;
    pins_t  pins;
    word_t  word;
    logic   out;
    logic   pred;
    pins_t  exp_pins;
  } row_t;

  localparam int NUM_ROWS = 35;
  localparam int TIMEOUT  = (NUM_ROWS + 4) * 4 + 20;

  logic   clk;
  logic   rst_n;
  instr_t instr;
  logic   instr_vld;
  slice_t in_data;
  pins_t  io_pins_in;
  slice_t out_data;
  logic   out_vld;
  pins_t  io_pins_out;
  logic   pred;

  row_t   rows [NUM_ROWS];
  row_t   exp_row;
  logic   check;
  int     check_idx;
  int     checked;
  int     errors;
  int     cycles = 0;

  idli_ex i_idli_ex (
    .i_ex_gck       (clk),
    .i_ex_rst_n     (rst_n),
    .i_ex_instr     (instr),
    .i_ex_instr_vld (instr_vld),
    .i_ex_in_data   (in_data),
    .o_ex_out_data  (out_data),
    .o_ex_out_vld   (out_vld),
    .i_ex_io_pins   (io_pins_in),
    .o_ex_io_pins   (io_pins_out),
    .o_ex_pred      (pred)
  );

  idli_ex_mon i_mon (
    .i_clk      (clk),
    .i_out_data (out_data),
    .i_out_vld  (out_vld),
    .i_pred     (pred),
    .i_io_pins  (io_pins_out),
    .i_check    (check),
    .i_row      (check_idx),
    .i_exp_word (exp_row.word),
    .i_exp_out  (exp_row.out),
    .i_exp_pred (exp_row.pred),
    .i_exp_pins (exp_row.exp_pins),
    .o_checked  (checked),
    .o_errors   (errors)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // The run is bounded by the table length plus a margin for reset.
  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
      $display("tests failed");
      $finish;
    end
  end

  task automatic put_row(input int idx, input logic [15:0] op_word, input logic vld,
                         input slice_t nib, input pins_t pins, input word_t word,
                         input logic out, input logic p, input pins_t epins);
    rows[idx] = {op_word, vld, nib, pins, word, out, p, epins};
  endtask

  // Registers: ZR is 15, IN is 14. Expected words are worked out by hand.
  task automatic load_table();
    put_row(0,  16'h01EF, 1, 4'hF, 4'h0, 16'h0000, 0, 0, 4'h0);  // r1 = 0x000F
    put_row(1,  16'h02EF, 1, 4'h1, 4'h0, 16'h0000, 0, 0, 4'h0);  // r2 = 0x0001
    put_row(2,  16'h801F, 1, 4'h0, 4'h0, 16'h000F, 1, 0, 4'h0);
    put_row(3,  16'h8012, 1, 4'h0, 4'h0, 16'h0010, 1, 0, 4'h0);  // Carry into slice 1.
    put_row(4,  16'h13F2, 1, 4'h0, 4'h0, 16'h0000, 0, 0, 4'h0);  // r3 = 0 - 1
    put_row(5,  16'h803F, 1, 4'h0, 4'h0, 16'hFFFF, 1, 0, 4'h0);
    put_row(6,  16'h0432, 1, 4'h0, 4'h0, 16'h0000, 0, 0, 4'h0);  // r4 wraps to zero
    put_row(7,  16'h804F, 1, 4'h0, 4'h0, 16'h0000, 1, 0, 4'h0);
    put_row(8,  16'h4531, 1, 4'h0, 4'h0, 16'h0000, 0, 0, 4'h0);  // r5 = r3 ^ r1
    put_row(9,  16'h805F, 1, 4'h0, 4'h0, 16'hFFF0, 1, 0, 4'h0);
    put_row(10, 16'h2631, 1, 4'h0, 4'h0, 16'h0000, 0, 0, 4'h0);  // r6 = r3 & r1
    put_row(11, 16'h3752, 1, 4'h0, 4'h0, 16'h0000, 0, 0, 4'h0);  // r7 = r5 | r2
    put_row(12, 16'h806F, 1, 4'h0, 4'h0, 16'h000F, 1, 0, 4'h0);
    put_row(13, 16'h8077, 1, 4'h0, 4'h0, 16'hFFE2, 1, 0, 4'h0);
    put_row(14, 16'h5F11, 1, 4'h0, 4'h0, 16'h0000, 0, 1, 4'h0);  // EQ true
    put_row(15, 16'h5F12, 1, 4'h0, 4'h0, 16'h0000, 0, 0, 4'h0);  // EQ false
    put_row(16, 16'h6F31, 1, 4'h0, 4'h0, 16'h0000, 0, 1, 4'h0);  // -1 < 15
    put_row(17, 16'h7F31, 1, 4'h0, 4'h0, 16'h0000, 0, 0, 4'h0);  // 0xFFFF < 15 unsigned
    put_row(18, 16'h7F13, 1, 4'h0, 4'h0, 16'h0000, 0, 1, 4'h0);
    put_row(19, 16'h6F13, 1, 4'h0, 4'h0, 16'h0000, 0, 0, 4'h0);
    put_row(20, 16'h5F11, 1, 4'h0, 4'h0, 16'h0000, 0, 1, 4'h0);
    // State 0x06 skips the next one, then runs two.
    put_row(21, 16'hB006, 1, 4'h0, 4'h0, 16'h0000, 0, 1, 4'h0);
    put_row(22, 16'h801F, 1, 4'h0, 4'h0, 16'h0000, 0, 1, 4'h0);
    put_row(23, 16'h802F, 1, 4'h0, 4'h0, 16'h0001, 1, 1, 4'h0);
    put_row(24, 16'h806F, 1, 4'h0, 4'h0, 16'h000F, 1, 1, 4'h0);
    put_row(25, 16'hA220, 1, 4'h0, 4'h0, 16'h0000, 0, 1, 4'h4);  // pin 2 from r2
    put_row(26, 16'hA010, 1, 4'h0, 4'h0, 16'h0000, 0, 1, 4'h5);  // pin 0 from r1
    put_row(27, 16'hA250, 1, 4'h0, 4'h0, 16'h0000, 0, 1, 4'h1);  // pin 2 from r5
    put_row(28, 16'h9380, 1, 4'h0, 4'h8, 16'h0000, 0, 1, 4'h1);  // r8 = pin 3
    put_row(29, 16'h808F, 1, 4'h0, 4'h0, 16'h0001, 1, 1, 4'h1);
    put_row(30, 16'h9190, 1, 4'h0, 4'h8, 16'h0000, 0, 1, 4'h1);  // r9 = pin 1
    put_row(31, 16'h8091, 1, 4'h0, 4'h0, 16'h000F, 1, 1, 4'h1);
    // Invalid slots change nothing.
    put_row(32, 16'h801F, 0, 4'h0, 4'h0, 16'h0000, 0, 1, 4'h1);
    put_row(33, 16'hA220, 0, 4'h0, 4'h0, 16'h0000, 0, 1, 4'h1);
    put_row(34, 16'h5F12, 0, 4'h0, 4'h0, 16'h0000, 0, 1, 4'h1);  // EQ false if run
  endtask

  // Rows are issued on the edge where the counter reaches 3. The input
  // nibble follows one cycle later so it is stable for the executing slot.
  // Row i-1 is checked just after row i has been sampled.
  initial begin
    instr      = '0;
    instr_vld  = 1'b0;
    in_data    = '0;
    io_pins_in = '0;
    check      = 1'b0;
    check_idx  = 0;
    exp_row    = '0;
    rst_n      = 1'b0;
    load_table();
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    for (int i = 0; i <= NUM_ROWS; i++) begin
      if (i < NUM_ROWS) begin
        instr      = rows[i].instr;
        instr_vld  = rows[i].vld;
        io_pins_in = rows[i].pins;
      end else begin
        instr     = 16'hF000;
        instr_vld = 1'b0;
      end
      @(posedge clk);
      #1;
      if (i < NUM_ROWS) begin
        in_data = rows[i].in_data;
      end
      if (i > 0) begin
        exp_row   = rows[i-1];
        check_idx = i - 1;
        check     = 1'b1;
      end
      @(posedge clk);
      #1 check = 1'b0;
      repeat (2) @(posedge clk);
      #1;
    end
    $display("%0d of %0d rows checked, %0d errors", checked, NUM_ROWS, errors);
    if (errors == 0 && checked == NUM_ROWS) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
verilog/idli_pkg.sv
verilog/idli_decode.sv
verilog/idli_rf.sv
verilog/idli_alu.sv
verilog/idli_pred.sv
verilog/idli_pins.sv
verilog/idli_ex.sv
tests/idli_ex_chk.sv
tests/idli_ex_mon.sv
tests/tb_idli_ex.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the execute core testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f --top-module tb_idli_ex -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -qx "all tests passed" sim.log; then
  exit 0
fi
exit 1
